//--- Makefile
SRCS := $(wildcard hdl/*.sv sim/*.sv)
BIN  := obj_dir/Vtb_axil_cfg_master

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) all.f
	verilator --binary --timing --assert -f all.f --top-module tb_axil_cfg_master -Mdir obj_dir

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- all.f
hdl/cfg_pkg.sv
hdl/axil_write_engine.sv
hdl/axil_read_engine.sv
hdl/cfg_sequencer.sv
hdl/axil_cfg_master.sv
sim/axil_mem_model.sv
sim/tb_axil_cfg_master.sv

//--- hdl/axil_cfg_master.sv
`timescale 1ns/1ps

module axil_cfg_master
  import cfg_pkg::*;
(
  input  logic       M_AXI_ACLK,
  input  logic       reset_start,
  // Write address
  output addr_t      M_AXI_AWADDR,
  output logic [2:0] M_AXI_AWPROT,
  output logic       M_AXI_AWVALID,
  input  logic       M_AXI_AWREADY,
  // Write data
  output data_t      M_AXI_WDATA,
  output logic [3:0] M_AXI_WSTRB,
  output logic       M_AXI_WVALID,
  input  logic       M_AXI_WREADY,
  // Write response
  input  resp_t      M_AXI_BRESP,
  input  logic       M_AXI_BVALID,
  output logic       M_AXI_BREADY,
  // Read address
  output addr_t      M_AXI_ARADDR,
  output logic [2:0] M_AXI_ARPROT,
  output logic       M_AXI_ARVALID,
  input  logic       M_AXI_ARREADY,
  // Read data
  input  data_t      M_AXI_RDATA,
  input  resp_t      M_AXI_RRESP,
  input  logic       M_AXI_RVALID,
  output logic       M_AXI_RREADY,
  // Run status
  output logic       done,
  output logic       success
);

  // Sequencer to write engine
  logic  wr_req;
  addr_t wr_addr;
  data_t wr_data;
  logic  wr_busy;
  logic  wr_done;
  logic  wr_err;

  // Sequencer to read engine
  logic  rd_req;
  addr_t rd_addr;
  logic  rd_busy;
  logic  rd_done;
  data_t rd_data;
  logic  rd_err;

  cfg_sequencer u_seq (
    .M_AXI_ACLK  (M_AXI_ACLK),
    .reset_start (reset_start),
    .wr_req      (wr_req),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .wr_busy     (wr_busy),
    .wr_done     (wr_done),
    .wr_err      (wr_err),
    .rd_req      (rd_req),
    .rd_addr     (rd_addr),
    .rd_busy     (rd_busy),
    .rd_done     (rd_done),
    .rd_data     (rd_data),
    .rd_err      (rd_err),
    .done        (done),
    .success     (success)
  );

  axil_write_engine u_wr (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .reset_start   (reset_start),
    .wr_req        (wr_req),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .M_AXI_AWADDR  (M_AXI_AWADDR),
    .M_AXI_AWPROT  (M_AXI_AWPROT),
    .M_AXI_AWVALID (M_AXI_AWVALID),
    .M_AXI_AWREADY (M_AXI_AWREADY),
    .M_AXI_WDATA   (M_AXI_WDATA),
    .M_AXI_WSTRB   (M_AXI_WSTRB),
    .M_AXI_WVALID  (M_AXI_WVALID),
    .M_AXI_WREADY  (M_AXI_WREADY),
    .M_AXI_BVALID  (M_AXI_BVALID),
    .M_AXI_BRESP   (M_AXI_BRESP),
    .M_AXI_BREADY  (M_AXI_BREADY),
    .wr_busy       (wr_busy),
    .wr_done       (wr_done),
    .wr_err        (wr_err)
  );

  axil_read_engine u_rd (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .reset_start   (reset_start),
    .rd_req        (rd_req),
    .rd_addr       (rd_addr),
    .M_AXI_ARADDR  (M_AXI_ARADDR),
    .M_AXI_ARPROT  (M_AXI_ARPROT),
    .M_AXI_ARVALID (M_AXI_ARVALID),
    .M_AXI_ARREADY (M_AXI_ARREADY),
    .M_AXI_RVALID  (M_AXI_RVALID),
    .M_AXI_RDATA   (M_AXI_RDATA),
    .M_AXI_RRESP   (M_AXI_RRESP),
    .M_AXI_RREADY  (M_AXI_RREADY),
    .rd_busy       (rd_busy),
    .rd_done       (rd_done),
    .rd_data       (rd_data),
    .rd_err        (rd_err)
  );

endmodule

//--- hdl/axil_read_engine.sv
`timescale 1ns/1ps

module axil_read_engine
  import cfg_pkg::*;
(
  input  logic       M_AXI_ACLK,
  input  logic       reset_start,
  // Request from the sequencer
  input  logic       rd_req,
  input  addr_t      rd_addr,
  // AR channel
  output addr_t      M_AXI_ARADDR,
  output logic [2:0] M_AXI_ARPROT,
  output logic       M_AXI_ARVALID,
  input  logic       M_AXI_ARREADY,
  // R channel
  input  logic       M_AXI_RVALID,
  input  data_t      M_AXI_RDATA,
  input  resp_t      M_AXI_RRESP,
  output logic       M_AXI_RREADY,
  // Result back to the sequencer
  output logic       rd_busy,
  output logic       rd_done,
  output data_t      rd_data,
  output logic       rd_err
);

  //////////////////////////////////////////////////
  // AR channel
  //////////////////////////////////////////////////

  // Address held until ARREADY
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (rd_req)
      M_AXI_ARADDR <= rd_addr;
  end

  assign M_AXI_ARPROT = PROT_NONE;

  // Raised on request, dropped on handshake
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!reset_start)
      M_AXI_ARVALID <= 1'b0;
    else if (M_AXI_ARVALID && M_AXI_ARREADY)
      M_AXI_ARVALID <= 1'b0;
    else if (rd_req)
      M_AXI_ARVALID <= 1'b1;
  end

  //////////////////////////////////////////////////
  // R channel
  //////////////////////////////////////////////////

  // Checker never stalls, so RREADY stays up
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!reset_start)
      M_AXI_RREADY <= 1'b0;
    else
      M_AXI_RREADY <= 1'b1;
  end

  // One read in flight, request to R handshake
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!reset_start)
      rd_busy <= 1'b0;
    else if (rd_done)
      rd_busy <= 1'b0;
    else if (rd_req)
      rd_busy <= 1'b1;
  end

  // Beat handed over in the handshake cycle
  assign rd_done = rd_busy && M_AXI_RVALID && M_AXI_RREADY;
  assign rd_data = M_AXI_RDATA;
  assign rd_err  = M_AXI_RRESP[1];

  // Read request persists through back-pressure
  a_ar_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!reset_start)
    M_AXI_ARVALID && !M_AXI_ARREADY |=> M_AXI_ARVALID && $stable(M_AXI_ARADDR))
    else $error("ARVALID or ARADDR changed before ARREADY");

endmodule

//--- hdl/axil_write_engine.sv
`timescale 1ns/1ps

module axil_write_engine
  import cfg_pkg::*;
(
  input  logic       M_AXI_ACLK,
  input  logic       reset_start,
  // Request from the sequencer
  input  logic       wr_req,
  input  addr_t      wr_addr,
  input  data_t      wr_data,
  // AW channel
  output addr_t      M_AXI_AWADDR,
  output logic [2:0] M_AXI_AWPROT,
  output logic       M_AXI_AWVALID,
  input  logic       M_AXI_AWREADY,
  // W channel
  output data_t      M_AXI_WDATA,
  output logic [3:0] M_AXI_WSTRB,
  output logic       M_AXI_WVALID,
  input  logic       M_AXI_WREADY,
  // B channel
  input  logic       M_AXI_BVALID,
  input  resp_t      M_AXI_BRESP,
  output logic       M_AXI_BREADY,
  // Status back to the sequencer
  output logic       wr_busy,
  output logic       wr_done,
  output logic       wr_err
);

  //////////////////////////////////////////////////
  // Address and data payload
  //////////////////////////////////////////////////

  // Captured once per request, held until both handshakes
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (wr_req)
    begin
      M_AXI_AWADDR <= wr_addr;
      M_AXI_WDATA  <= wr_data;
    end
  end

  // Single beat, full word, unprivileged
  assign M_AXI_AWPROT = PROT_NONE;
  assign M_AXI_WSTRB  = STRB_ALL;

  //////////////////////////////////////////////////
  // AW and W valid
  //////////////////////////////////////////////////

  // Both rise on the request, each drops on its own handshake
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!reset_start)
    begin
      M_AXI_AWVALID <= 1'b0;
      M_AXI_WVALID  <= 1'b0;
    end
    else
    begin
      if (M_AXI_AWVALID && M_AXI_AWREADY)
        M_AXI_AWVALID <= 1'b0;
      else if (wr_req)
        M_AXI_AWVALID <= 1'b1;
      if (M_AXI_WVALID && M_AXI_WREADY)
        M_AXI_WVALID <= 1'b0;
      else if (wr_req)
        M_AXI_WVALID <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // B response tracking
  //////////////////////////////////////////////////

  // Always ready for a response once out of reset
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!reset_start)
      M_AXI_BREADY <= 1'b0;
    else
      M_AXI_BREADY <= 1'b1;
  end

  // Outstanding write, open from request to B handshake
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!reset_start)
      wr_busy <= 1'b0;
    else if (wr_done)
      wr_busy <= 1'b0;
    else if (wr_req)
      wr_busy <= 1'b1;
  end

  // Completion pulse in the B handshake cycle
  assign wr_done = wr_busy && M_AXI_BVALID && M_AXI_BREADY;
  assign wr_err  = M_AXI_BRESP[1];

  // Address must not move or vanish while the slave stalls
  a_aw_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!reset_start)
    M_AXI_AWVALID && !M_AXI_AWREADY |=> M_AXI_AWVALID && $stable(M_AXI_AWADDR))
    else $error("AWVALID or AWADDR changed before AWREADY");

  // Sequencer issues one write at a time
  a_req_idle: assert property (@(posedge M_AXI_ACLK) disable iff (!reset_start)
    wr_req |-> !wr_busy)
    else $error("wr_req while a write is outstanding");

endmodule

//--- hdl/cfg_pkg.sv
package cfg_pkg;

  ////////////////////////////////////////////////////
  // Bus and table types
  ////////////////////////////////////////////////////

  // Byte address of one AXI4-Lite transfer
  typedef logic [31:0] addr_t;
  // One register word
  typedef logic [31:0] data_t;
  // Response code, bit 1 flags an error
  typedef logic [1:0]  resp_t;
  // Table index
  typedef logic [7:0]  idx_t;

  // Table size and placement
  localparam idx_t  NUM_COMMANDS = 8'd16;
  localparam idx_t  LAST_IDX     = NUM_COMMANDS - 8'd1;
  localparam addr_t BASE_ADDR    = 32'h4000_0000;
  localparam data_t DATA_BASE    = 32'hC0DE_0000;

  // Fixed transfer qualifiers
  localparam logic [2:0] PROT_NONE = 3'b000;
  localparam logic [3:0] STRB_ALL  = 4'hF;

  // Named responses
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Sequencer phases
  typedef enum logic [2:0] {S_WRITE, S_WAIT_B, S_READ, S_WAIT_R, S_DONE} seq_state_t;

  // Entry address, word stride from the base
  function automatic addr_t table_addr(idx_t idx);
    return BASE_ADDR + {22'd0, idx, 2'b00};
  endfunction

  // Entry data, index in the low byte
  function automatic data_t table_data(idx_t idx);
    return {DATA_BASE[31:8], idx};
  endfunction

endpackage

//--- hdl/cfg_sequencer.sv
`timescale 1ns/1ps

module cfg_sequencer
  import cfg_pkg::*;
(
  input  logic  M_AXI_ACLK,
  input  logic  reset_start,
  // Write engine
  output logic  wr_req,
  output addr_t wr_addr,
  output data_t wr_data,
  input  logic  wr_busy,
  input  logic  wr_done,
  input  logic  wr_err,
  // Read engine
  output logic  rd_req,
  output addr_t rd_addr,
  input  logic  rd_busy,
  input  logic  rd_done,
  input  data_t rd_data,
  input  logic  rd_err,
  // Run status
  output logic  done,
  output logic  success
);

  seq_state_t state;
  idx_t       idx;
  data_t      expected;
  logic       err_flag;
  logic       last;
  logic       rd_bad;

  // Final table entry reached
  assign last = (idx == LAST_IDX);

  // Error response or data mismatch on this read beat
  assign rd_bad = rd_err || (rd_data != expected);

  //////////////////////////////////////////////////
  // Phase control
  //////////////////////////////////////////////////

  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!reset_start)
    begin
      state  <= S_WRITE;
      idx    <= '0;
      wr_req <= 1'b0;
      rd_req <= 1'b0;
      done   <= 1'b0;
    end
    else
    begin
      // Requests are single-cycle pulses
      wr_req <= 1'b0;
      rd_req <= 1'b0;
      case (state)
        S_WRITE:
        begin
          wr_req <= 1'b1;
          state  <= S_WAIT_B;
        end
        S_WAIT_B:
        begin
          if (wr_done)
          begin
            if (last)
            begin
              // All writes committed, start readback at entry 0
              idx   <= '0;
              state <= S_READ;
            end
            else
            begin
              idx   <= idx + 8'd1;
              state <= S_WRITE;
            end
          end
        end
        S_READ:
        begin
          rd_req <= 1'b1;
          state  <= S_WAIT_R;
        end
        S_WAIT_R:
        begin
          if (rd_done)
          begin
            if (last)
            begin
              done  <= 1'b1;
              state <= S_DONE;
            end
            else
            begin
              idx   <= idx + 8'd1;
              state <= S_READ;
            end
          end
        end
        default:
        begin
          // Run finished, hold until next reset
          state <= S_DONE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Table payload
  //////////////////////////////////////////////////

  // Loaded alongside the request pulse
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (state == S_WRITE)
    begin
      wr_addr <= table_addr(idx);
      wr_data <= table_data(idx);
    end
    if (state == S_READ)
    begin
      rd_addr  <= table_addr(idx);
      expected <= table_data(idx);
    end
  end

  //////////////////////////////////////////////////
  // Error register and result
  //////////////////////////////////////////////////

  // Sticky over the whole run
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!reset_start)
      err_flag <= 1'b0;
    else if ((wr_done && wr_err) || (rd_done && rd_bad))
      err_flag <= 1'b1;
  end

  // Final beat error lands in err_flag on the same edge as done
  assign success = done && !err_flag;

  // Readback never overlaps an open write or read
  a_rd_after_b: assert property (@(posedge M_AXI_ACLK) disable iff (!reset_start)
    rd_req |-> !wr_busy && !rd_busy)
    else $error("rd_req while a transfer is outstanding");

endmodule

//--- sim/axil_mem_model.sv
`timescale 1ns/1ps

module axil_mem_model
  import cfg_pkg::*;
(
  input  logic       M_AXI_ACLK,
  input  logic       reset_start,
  // Random word and stall mask, bits 0..4 are AW, W, B, AR, R
  input  logic [31:0] rnd,
  input  logic [4:0]  bp_mask,
  // Fault kind 0 none, 1 write SLVERR, 2 read SLVERR, 3 corrupt read data
  input  logic [1:0]  fault_kind,
  input  idx_t        fault_idx,
  // Write side
  input  addr_t       M_AXI_AWADDR,
  input  logic        M_AXI_AWVALID,
  output logic        M_AXI_AWREADY,
  input  data_t       M_AXI_WDATA,
  input  logic        M_AXI_WVALID,
  output logic        M_AXI_WREADY,
  output resp_t       M_AXI_BRESP,
  output logic        M_AXI_BVALID,
  input  logic        M_AXI_BREADY,
  // Read side
  input  addr_t       M_AXI_ARADDR,
  input  logic        M_AXI_ARVALID,
  output logic        M_AXI_ARREADY,
  output data_t       M_AXI_RDATA,
  output resp_t       M_AXI_RRESP,
  output logic        M_AXI_RVALID,
  input  logic        M_AXI_RREADY
);

  data_t mem [0:15];
  logic  aw_have;
  logic  w_have;
  addr_t aw_addr;
  data_t w_data;
  logic  ar_have;
  addr_t ar_addr;
  idx_t  wr_cnt;
  idx_t  rd_cnt;
  logic  [4:0] go;

  // Channel may move this cycle
  assign go = ~(bp_mask & rnd[4:0]);

  ////////////////////////////////////////////////////
  // Ready outputs
  ////////////////////////////////////////////////////

  assign M_AXI_AWREADY = reset_start && !aw_have && !M_AXI_BVALID && go[0];
  assign M_AXI_WREADY  = reset_start && !w_have && !M_AXI_BVALID && go[1];
  assign M_AXI_ARREADY = reset_start && !ar_have && !M_AXI_RVALID && go[3];

  // Write commit and B response
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!reset_start)
    begin
      aw_have      <= 1'b0;
      w_have       <= 1'b0;
      M_AXI_BVALID <= 1'b0;
      M_AXI_BRESP  <= RESP_OKAY;
      wr_cnt       <= '0;
      // Fill from the word index so stale reads show up
      for (int i = 0; i < 16; i++)
        mem[i] <= 32'hBAD0_0000 | data_t'(i);
    end
    else
    begin
      if (M_AXI_AWVALID && M_AXI_AWREADY)
      begin
        aw_have <= 1'b1;
        aw_addr <= M_AXI_AWADDR;
      end
      if (M_AXI_WVALID && M_AXI_WREADY)
      begin
        w_have <= 1'b1;
        w_data <= M_AXI_WDATA;
      end
      if (aw_have && w_have && !M_AXI_BVALID && go[2])
      begin
        mem[aw_addr[5:2]] <= w_data;
        M_AXI_BVALID      <= 1'b1;
        M_AXI_BRESP       <= (fault_kind == 2'd1 && wr_cnt == fault_idx) ? RESP_SLVERR : RESP_OKAY;
        wr_cnt            <= wr_cnt + 8'd1;
        aw_have           <= 1'b0;
        w_have            <= 1'b0;
      end
      else if (M_AXI_BVALID && M_AXI_BREADY)
        M_AXI_BVALID <= 1'b0;
    end
  end

  // Read lookup and R beat
  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!reset_start)
    begin
      ar_have      <= 1'b0;
      M_AXI_RVALID <= 1'b0;
      M_AXI_RRESP  <= RESP_OKAY;
      M_AXI_RDATA  <= '0;
      rd_cnt       <= '0;
    end
    else
    begin
      if (M_AXI_ARVALID && M_AXI_ARREADY)
      begin
        ar_have <= 1'b1;
        ar_addr <= M_AXI_ARADDR;
      end
      if (ar_have && !M_AXI_RVALID && go[4])
      begin
        // Corruption flips one bit of the stored word
        M_AXI_RDATA  <= mem[ar_addr[5:2]] ^
                        ((fault_kind == 2'd3 && rd_cnt == fault_idx) ? 32'h0000_0100 : 32'h0);
        M_AXI_RRESP  <= (fault_kind == 2'd2 && rd_cnt == fault_idx) ? RESP_SLVERR : RESP_OKAY;
        M_AXI_RVALID <= 1'b1;
        rd_cnt       <= rd_cnt + 8'd1;
        ar_have      <= 1'b0;
      end
      else if (M_AXI_RVALID && M_AXI_RREADY)
        M_AXI_RVALID <= 1'b0;
    end
  end

endmodule

//--- sim/tb_axil_cfg_master.sv
`timescale 1ns/1ps

module tb_axil_cfg_master
  import cfg_pkg::*;
();

  localparam int NUM_CASES   = 6;
  localparam int NUM_CMD     = int'(NUM_COMMANDS);
  localparam int WORST_DELAY = 32;
  localparam int RESET_CYC   = 16;
  localparam int LIMIT       = NUM_CASES * NUM_CMD * 2 * WORST_DELAY + NUM_CASES * (RESET_CYC + 4);

  ////////////////////////////////////////////////////
  // Case table
  ////////////////////////////////////////////////////

  // Stall mask, fault kind, fault index, expected success
  logic [4:0] case_mask  [NUM_CASES] = '{5'h00, 5'h1F, 5'h1F, 5'h15, 5'h0A, 5'h1F};
  logic [1:0] case_fault [NUM_CASES] = '{2'd0, 2'd0, 2'd1, 2'd2, 2'd3, 2'd1};
  idx_t       case_k     [NUM_CASES] = '{8'd0, 8'd0, 8'd5, 8'd0, 8'd15, 8'd15};
  logic       case_exp   [NUM_CASES] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};

  logic        M_AXI_ACLK = 1'b0;
  logic        reset_start = 1'b0;
  logic [31:0] rnd = 32'hacc9e303;
  logic [4:0]  bp_mask = '0;
  logic [1:0]  fault_kind = '0;
  idx_t        fault_idx = '0;

  addr_t M_AXI_AWADDR, M_AXI_ARADDR;
  data_t M_AXI_WDATA, M_AXI_RDATA;
  resp_t M_AXI_BRESP, M_AXI_RRESP;
  logic [2:0] M_AXI_AWPROT, M_AXI_ARPROT;
  logic [3:0] M_AXI_WSTRB;
  logic M_AXI_AWVALID, M_AXI_AWREADY, M_AXI_WVALID, M_AXI_WREADY;
  logic M_AXI_BVALID, M_AXI_BREADY, M_AXI_ARVALID, M_AXI_ARREADY;
  logic M_AXI_RVALID, M_AXI_RREADY;
  logic done, success;

  int mon_errors = 0;
  int seq_errors = 0;
  int total_cyc  = 0;
  int aw_cnt, w_cnt, b_cnt, ar_cnt, r_cnt;
  int mon_cyc, last_r_cyc;
  logic done_seen;
  logic p_awv, p_awr, p_wv, p_wr, p_arv, p_arr;
  addr_t p_awaddr, p_araddr;
  data_t p_wdata;

  always #50 M_AXI_ACLK = ~M_AXI_ACLK;

  axil_cfg_master u_dut (.*);

  axil_mem_model u_mem (.*);

  // Expected table rebuilt from the entry rule
  function automatic addr_t exp_addr(int i);
    return BASE_ADDR + addr_t'(i * 4);
  endfunction

  function automatic data_t exp_data(int i);
    return DATA_BASE | data_t'(i);
  endfunction

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("FAILED %0t %s: got %h expected %h", $time, name, got, exp);
  endtask

  // New stall pattern every cycle
  always @(posedge M_AXI_ACLK)
    rnd <= xorshift(rnd);

  // Hang guard over the whole run
  always @(posedge M_AXI_ACLK)
  begin
    total_cyc++;
    if (total_cyc > LIMIT)
    begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////
  // Bus monitor
  ////////////////////////////////////////////////////

  always @(posedge M_AXI_ACLK)
  begin
    if (!reset_start)
    begin
      aw_cnt = 0;
      w_cnt = 0;
      b_cnt = 0;
      ar_cnt = 0;
      r_cnt = 0;
      mon_cyc = 0;
      last_r_cyc = -10;
      done_seen = 1'b0;
      p_awv = 1'b0;
      p_wv = 1'b0;
      p_arv = 1'b0;
      p_awr = 1'b0;
      p_wr = 1'b0;
      p_arr = 1'b0;
    end
    else
    begin
      mon_cyc++;
      // VALID and payload held through back-pressure
      if (p_awv && !p_awr)
      begin
        if (!M_AXI_AWVALID)
        begin
          $display("AWVALID dropped before AWREADY at %0t", $time);
          mon_errors++;
        end
        else if (M_AXI_AWADDR != p_awaddr)
        begin
          report_mismatch("M_AXI_AWADDR", M_AXI_AWADDR, p_awaddr);
          mon_errors++;
        end
      end
      if (p_wv && !p_wr)
      begin
        if (!M_AXI_WVALID)
        begin
          $display("WVALID dropped before WREADY at %0t", $time);
          mon_errors++;
        end
        else if (M_AXI_WDATA != p_wdata)
        begin
          report_mismatch("M_AXI_WDATA", M_AXI_WDATA, p_wdata);
          mon_errors++;
        end
      end
      if (p_arv && !p_arr)
      begin
        if (!M_AXI_ARVALID)
        begin
          $display("ARVALID dropped before ARREADY at %0t", $time);
          mon_errors++;
        end
        else if (M_AXI_ARADDR != p_araddr)
        begin
          report_mismatch("M_AXI_ARADDR", M_AXI_ARADDR, p_araddr);
          mon_errors++;
        end
      end
      // At most one transfer outstanding
      if (M_AXI_AWVALID && (aw_cnt != b_cnt || ar_cnt != r_cnt))
      begin
        $display("Write address presented while a transfer was outstanding at %0t", $time);
        mon_errors++;
      end
      if (M_AXI_WVALID && w_cnt != b_cnt)
      begin
        $display("Write data presented while a write was outstanding at %0t", $time);
        mon_errors++;
      end
      if (M_AXI_ARVALID && (ar_cnt != r_cnt || aw_cnt != b_cnt))
      begin
        $display("Read address presented while a transfer was outstanding at %0t", $time);
        mon_errors++;
      end
      // Write address
      if (M_AXI_AWVALID && M_AXI_AWREADY)
      begin
        if (M_AXI_AWADDR != exp_addr(aw_cnt))
        begin
          report_mismatch("M_AXI_AWADDR", M_AXI_AWADDR, exp_addr(aw_cnt));
          mon_errors++;
        end
        if (M_AXI_AWPROT != 3'b000)
        begin
          report_mismatch("M_AXI_AWPROT", 32'(M_AXI_AWPROT), 32'h0);
          mon_errors++;
        end
        aw_cnt++;
      end
      // Write data
      if (M_AXI_WVALID && M_AXI_WREADY)
      begin
        if (M_AXI_WDATA != exp_data(w_cnt))
        begin
          report_mismatch("M_AXI_WDATA", M_AXI_WDATA, exp_data(w_cnt));
          mon_errors++;
        end
        if (M_AXI_WSTRB != 4'hF)
        begin
          report_mismatch("M_AXI_WSTRB", 32'(M_AXI_WSTRB), 32'hF);
          mon_errors++;
        end
        w_cnt++;
      end
      if (M_AXI_BVALID && M_AXI_BREADY)
        b_cnt++;
      // Read address only after every B
      if (M_AXI_ARVALID && M_AXI_ARREADY)
      begin
        if (b_cnt != NUM_CMD)
        begin
          $display("Read issued before the final write response at %0t", $time);
          mon_errors++;
        end
        if (M_AXI_ARADDR != exp_addr(ar_cnt))
        begin
          report_mismatch("M_AXI_ARADDR", M_AXI_ARADDR, exp_addr(ar_cnt));
          mon_errors++;
        end
        if (M_AXI_ARPROT != 3'b000)
        begin
          report_mismatch("M_AXI_ARPROT", 32'(M_AXI_ARPROT), 32'h0);
          mon_errors++;
        end
        ar_cnt++;
      end
      if (M_AXI_RVALID && M_AXI_RREADY)
      begin
        r_cnt++;
        last_r_cyc = mon_cyc;
      end
      // success never ahead of done
      if (success && !done)
      begin
        $display("success high before done at %0t", $time);
        mon_errors++;
      end
      // done one cycle after the last R
      if (done && !done_seen)
      begin
        done_seen = 1'b1;
        if (last_r_cyc != mon_cyc - 1)
        begin
          report_mismatch("done latency", 32'(mon_cyc - last_r_cyc), 32'h1);
          mon_errors++;
        end
      end
      p_awv = M_AXI_AWVALID;
      p_awr = M_AXI_AWREADY;
      p_awaddr = M_AXI_AWADDR;
      p_wv = M_AXI_WVALID;
      p_wr = M_AXI_WREADY;
      p_wdata = M_AXI_WDATA;
      p_arv = M_AXI_ARVALID;
      p_arr = M_AXI_ARREADY;
      p_araddr = M_AXI_ARADDR;
    end
  end

  ////////////////////////////////////////////////////
  // Case sequence
  ////////////////////////////////////////////////////

  initial
  begin
    int n;
    logic [11:0] idle;
    for (int c = 0; c < NUM_CASES; c++)
    begin
      @(posedge M_AXI_ACLK);
      reset_start <= 1'b0;
      bp_mask     <= case_mask[c];
      fault_kind  <= case_fault[c];
      fault_idx   <= case_k[c];
      // Bus quiet once the reset edge has been taken
      repeat (RESET_CYC - 1)
      begin
        @(posedge M_AXI_ACLK);
        @(negedge M_AXI_ACLK);
        idle = {M_AXI_AWVALID, M_AXI_WVALID, M_AXI_ARVALID, M_AXI_BVALID, M_AXI_RVALID,
                M_AXI_AWREADY, M_AXI_WREADY, M_AXI_ARREADY, M_AXI_BREADY, M_AXI_RREADY,
                done, success};
        if (idle != 12'h000)
        begin
          report_mismatch("reset outputs", 32'(idle), 32'h0);
          seq_errors++;
        end
      end
      @(posedge M_AXI_ACLK);
      reset_start <= 1'b1;
      // Count edges with reset released until AWVALID shows
      n = 0;
      while (n < 8)
      begin
        @(posedge M_AXI_ACLK);
        n++;
        @(negedge M_AXI_ACLK);
        if (M_AXI_AWVALID)
          break;
      end
      if (n != 2)
      begin
        report_mismatch("first AWVALID cycle", 32'(n), 32'd2);
        seq_errors++;
      end
      while (!done)
        @(negedge M_AXI_ACLK);
      if (success != case_exp[c])
      begin
        report_mismatch("success", 32'(success), 32'(case_exp[c]));
        seq_errors++;
      end
      if (aw_cnt != NUM_CMD || w_cnt != NUM_CMD || b_cnt != NUM_CMD ||
          ar_cnt != NUM_CMD || r_cnt != NUM_CMD)
      begin
        $display("Case %0d did not complete every index", c);
        seq_errors++;
      end
      if (case_fault[c] == 2'd0)
      begin
        for (int i = 0; i < NUM_CMD; i++)
        begin
          if (u_mem.mem[i] != exp_data(i))
          begin
            report_mismatch("u_mem.mem", u_mem.mem[i], exp_data(i));
            seq_errors++;
          end
        end
      end
    end
    $display("Errors: monitor %0d, sequence %0d, total %0d",
             mon_errors, seq_errors, mon_errors + seq_errors);
    if (mon_errors + seq_errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule
